//--- source/net_port_pkg.sv
package net_port_pkg;

    // --------------------------------------------------
    // destination and ingress port encodings.
    // --------------------------------------------------

    // port type, 3 bits.
    // codes above UNSET are reserved.
    typedef enum logic [2:0] {
        PHY     = 3'h0,
        PF      = 3'h1,
        VF0     = 3'h2,
        APP_IGR = 3'h3,
        VF2     = 3'h4,
        UNSET   = 3'h5
    } port_typ_e;

    typedef enum logic {
        P0 = 1'b0,
        P1 = 1'b1
    } port_num_e;

    // carried as tid (ingress port) and tdest (destination).
    typedef struct packed {
        port_typ_e typ;
        port_num_e num;
    } port_t;

    localparam int PORT_WID = $bits(port_t);

endpackage : net_port_pkg

//--- source/p4_meta_pkg.sv
package p4_meta_pkg;

    // --------------------------------------------------
    // metadata that travels with packets to the processor.
    // --------------------------------------------------

    localparam int TIMESTAMP_WID = 32;

    // processor port index, one bit for two ports.
    typedef logic [0:0] proc_port_t;

    // tuser field of the packet stream.
    typedef struct packed {
        proc_port_t               proc_port;
        logic [TIMESTAMP_WID-1:0] timestamp;
    } pkt_meta_t;

    // --------------------------------------------------
    // merge arbiter state.
    // --------------------------------------------------

    // IDLE picks a lane, SERVE_Px holds it until tlast.
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        SERVE_P0 = 2'd1,
        SERVE_P1 = 2'd2
    } merge_state_e;

endpackage : p4_meta_pkg

//--- source/pkt_stream_if.sv
`timescale 1ns/10ps

// packet stream with valid/ready handshake.
// a beat moves on a clock edge with tvalid and tready both high.
interface pkt_stream_if #(
    parameter int DATA_BYTES = 8
);

    logic                        tvalid;
    logic                        tready;
    logic [DATA_BYTES*8-1:0]     tdata;
    logic [DATA_BYTES-1:0]       tkeep;
    logic                        tlast;
    net_port_pkg::port_t         tid;
    net_port_pkg::port_t         tdest;
    p4_meta_pkg::pkt_meta_t      tuser;

    // source side.
    modport tx (
        output tvalid,
        output tdata,
        output tkeep,
        output tlast,
        output tid,
        output tdest,
        output tuser,
        input  tready
    );

    // sink side.
    modport rx (
        input  tvalid,
        input  tdata,
        input  tkeep,
        input  tlast,
        input  tid,
        input  tdest,
        input  tuser,
        output tready
    );

endinterface : pkt_stream_if

//--- source/port_lane.sv
`timescale 1ns/10ps

module port_lane #(
    parameter int DATA_BYTES = 8,
    parameter int LANE_ID    = 0
) (
    input  logic                                  core_clk,
    input  logic                                  core_rstn,
    input  logic [p4_meta_pkg::TIMESTAMP_WID-1:0] timestamp,
    pkt_stream_if.rx                              in_s,
    pkt_stream_if.tx                              out_s
);

    // --------------------------------------------------
    // packet framing and drop decision.
    // --------------------------------------------------
    logic                                  sop;
    logic                                  drop_pkt;
    logic [p4_meta_pkg::TIMESTAMP_WID-1:0] ts_cap;

    logic                                  in_xfer;
    logic                                  unset_dest;
    logic                                  zero_len;
    logic                                  drop_beat;
    logic [p4_meta_pkg::TIMESTAMP_WID-1:0] pkt_ts;

    // output register.
    logic                                  out_vld;
    logic [DATA_BYTES*8-1:0]               out_data;
    logic [DATA_BYTES-1:0]                 out_keep;
    logic                                  out_last;
    net_port_pkg::port_t                   out_tid;
    net_port_pkg::port_t                   out_tdest;
    logic [p4_meta_pkg::TIMESTAMP_WID-1:0] out_ts;

    assign unset_dest = (in_s.tdest.typ == net_port_pkg::UNSET);
    assign zero_len   = in_s.tlast && (in_s.tkeep == '0);

    // the first beat decides, later beats follow the stored flag.
    assign drop_beat = sop ? (unset_dest || zero_len) : drop_pkt;

    // dropped beats are always taken so the source never stalls on them.
    assign in_s.tready = !out_vld || out_s.tready || drop_beat;
    assign in_xfer     = in_s.tvalid && in_s.tready;

    // first beat carries the live timestamp, the rest reuse the capture.
    assign pkt_ts = sop ? timestamp : ts_cap;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            sop      <= 1'b1;
            drop_pkt <= 1'b0;
        end else if (in_xfer) begin
            sop <= in_s.tlast;
            if (in_s.tlast) begin
                drop_pkt <= 1'b0;
            end else if (sop) begin
                drop_pkt <= unset_dest;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_xfer && sop) begin
            ts_cap <= timestamp;
        end
    end

    // --------------------------------------------------
    // one-stage output register.
    // --------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            out_vld <= 1'b0;
        end else if (in_xfer && !drop_beat) begin
            out_vld <= 1'b1;
        end else if (out_s.tready) begin
            out_vld <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_xfer && !drop_beat) begin
            out_data  <= in_s.tdata;
            out_keep  <= in_s.tkeep;
            out_last  <= in_s.tlast;
            out_tid   <= in_s.tid;
            out_tdest <= in_s.tdest;
            out_ts    <= pkt_ts;
        end
    end

    assign out_s.tvalid          = out_vld;
    assign out_s.tdata           = out_data;
    assign out_s.tkeep           = out_keep;
    assign out_s.tlast           = out_last;
    assign out_s.tid             = out_tid;
    assign out_s.tdest           = out_tdest;
    assign out_s.tuser.proc_port = p4_meta_pkg::proc_port_t'(LANE_ID);
    assign out_s.tuser.timestamp = out_ts;

endmodule : port_lane

//--- source/pkt_merge.sv
`timescale 1ns/10ps

module pkt_merge #(
    parameter int DATA_BYTES = 8
) (
    input  logic                    core_clk,
    input  logic                    core_rstn,

    pkt_stream_if.rx                lane0_s,
    pkt_stream_if.rx                lane1_s,

    output logic                    out_tvalid,
    output logic [DATA_BYTES*8-1:0] out_tdata,
    output logic [DATA_BYTES-1:0]   out_tkeep,
    output logic                    out_tlast,
    output net_port_pkg::port_t     out_tid,
    output net_port_pkg::port_t     out_tdest,
    output p4_meta_pkg::pkt_meta_t  out_meta,
    output logic                    out_meta_valid,
    input  logic                    out_tready
);

    // --------------------------------------------------
    // arbitration state.
    // --------------------------------------------------
    p4_meta_pkg::merge_state_e state;
    p4_meta_pkg::merge_state_e state_nxt;

    logic last_p1;
    logic first_beat;
    logic grant_p1;
    logic out_xfer;
    logic pkt_end;

    // lane that is not served last wins a tie at a packet boundary.
    always_comb begin
        case (state)
            p4_meta_pkg::SERVE_P0: grant_p1 = 1'b0;
            p4_meta_pkg::SERVE_P1: grant_p1 = 1'b1;
            default:               grant_p1 = lane1_s.tvalid && (!lane0_s.tvalid || !last_p1);
        endcase
    end

    assign out_xfer = out_tvalid && out_tready;
    assign pkt_end  = out_xfer && out_tlast;

    // lock onto the chosen lane unless its packet finished in one beat.
    always_comb begin
        state_nxt = state;
        case (state)
            p4_meta_pkg::IDLE: begin
                if (out_tvalid && !pkt_end) begin
                    state_nxt = grant_p1 ? p4_meta_pkg::SERVE_P1 : p4_meta_pkg::SERVE_P0;
                end
            end
            p4_meta_pkg::SERVE_P0,
            p4_meta_pkg::SERVE_P1: begin
                if (pkt_end) begin
                    state_nxt = p4_meta_pkg::IDLE;
                end
            end
            default: state_nxt = p4_meta_pkg::IDLE;
        endcase
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            state      <= p4_meta_pkg::IDLE;
            last_p1    <= 1'b1;
            first_beat <= 1'b1;
        end else begin
            state <= state_nxt;
            if (pkt_end) begin
                last_p1 <= grant_p1;
            end
            if (out_xfer) begin
                first_beat <= out_tlast;
            end
        end
    end

    // --------------------------------------------------
    // output mux.
    // --------------------------------------------------
    always_comb begin
        if (grant_p1) begin
            out_tvalid = lane1_s.tvalid;
            out_tdata  = lane1_s.tdata;
            out_tkeep  = lane1_s.tkeep;
            out_tlast  = lane1_s.tlast;
            out_tid    = lane1_s.tid;
            out_tdest  = lane1_s.tdest;
            out_meta   = lane1_s.tuser;
        end else begin
            out_tvalid = lane0_s.tvalid;
            out_tdata  = lane0_s.tdata;
            out_tkeep  = lane0_s.tkeep;
            out_tlast  = lane0_s.tlast;
            out_tid    = lane0_s.tid;
            out_tdest  = lane0_s.tdest;
            out_meta   = lane0_s.tuser;
        end
    end

    assign out_meta_valid = out_tvalid && first_beat;

    // only the granted lane sees ready.
    assign lane0_s.tready = !grant_p1 && out_tready;
    assign lane1_s.tready = grant_p1 && out_tready;

endmodule : pkt_merge

//--- source/p4_ingress.sv
`timescale 1ns/10ps

module p4_ingress #(
    parameter int DATA_BYTES = 8
) (
    input  logic                                  core_clk,
    input  logic                                  core_rstn,
    input  logic [p4_meta_pkg::TIMESTAMP_WID-1:0] timestamp,

    // processor port 0.
    input  logic                                  in0_tvalid,
    output logic                                  in0_tready,
    input  logic [DATA_BYTES*8-1:0]               in0_tdata,
    input  logic [DATA_BYTES-1:0]                 in0_tkeep,
    input  logic                                  in0_tlast,
    input  net_port_pkg::port_t                   in0_tid,
    input  net_port_pkg::port_t                   in0_tdest,

    // processor port 1.
    input  logic                                  in1_tvalid,
    output logic                                  in1_tready,
    input  logic [DATA_BYTES*8-1:0]               in1_tdata,
    input  logic [DATA_BYTES-1:0]                 in1_tkeep,
    input  logic                                  in1_tlast,
    input  net_port_pkg::port_t                   in1_tid,
    input  net_port_pkg::port_t                   in1_tdest,

    // merged stream toward the processor.
    output logic                                  out_tvalid,
    output logic [DATA_BYTES*8-1:0]               out_tdata,
    output logic [DATA_BYTES-1:0]                 out_tkeep,
    output logic                                  out_tlast,
    output net_port_pkg::port_t                   out_tid,
    output net_port_pkg::port_t                   out_tdest,
    output p4_meta_pkg::pkt_meta_t                out_meta,
    output logic                                  out_meta_valid,
    input  logic                                  out_tready
);

    pkt_stream_if #(.DATA_BYTES(DATA_BYTES)) in0_s ();
    pkt_stream_if #(.DATA_BYTES(DATA_BYTES)) in1_s ();
    pkt_stream_if #(.DATA_BYTES(DATA_BYTES)) lane0_s ();
    pkt_stream_if #(.DATA_BYTES(DATA_BYTES)) lane1_s ();

    // --------------------------------------------------
    // input ports onto the lane streams.
    // --------------------------------------------------
    assign in0_s.tvalid = in0_tvalid;
    assign in0_s.tdata  = in0_tdata;
    assign in0_s.tkeep  = in0_tkeep;
    assign in0_s.tlast  = in0_tlast;
    assign in0_s.tid    = in0_tid;
    assign in0_s.tdest  = in0_tdest;
    assign in0_s.tuser  = '0;
    assign in0_tready   = in0_s.tready;

    assign in1_s.tvalid = in1_tvalid;
    assign in1_s.tdata  = in1_tdata;
    assign in1_s.tkeep  = in1_tkeep;
    assign in1_s.tlast  = in1_tlast;
    assign in1_s.tid    = in1_tid;
    assign in1_s.tdest  = in1_tdest;
    assign in1_s.tuser  = '0;
    assign in1_tready   = in1_s.tready;

    // --------------------------------------------------
    // per-port lanes and merge.
    // --------------------------------------------------
    port_lane #(.DATA_BYTES(DATA_BYTES), .LANE_ID(0)) lane0 (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .timestamp (timestamp),
        .in_s      (in0_s),
        .out_s     (lane0_s)
    );

    port_lane #(.DATA_BYTES(DATA_BYTES), .LANE_ID(1)) lane1 (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .timestamp (timestamp),
        .in_s      (in1_s),
        .out_s     (lane1_s)
    );

    pkt_merge #(.DATA_BYTES(DATA_BYTES)) merge (
        .core_clk       (core_clk),
        .core_rstn      (core_rstn),
        .lane0_s        (lane0_s),
        .lane1_s        (lane1_s),
        .out_tvalid     (out_tvalid),
        .out_tdata      (out_tdata),
        .out_tkeep      (out_tkeep),
        .out_tlast      (out_tlast),
        .out_tid        (out_tid),
        .out_tdest      (out_tdest),
        .out_meta       (out_meta),
        .out_meta_valid (out_meta_valid),
        .out_tready     (out_tready)
    );

endmodule : p4_ingress

//--- test/p4_ingress_asserts.sv
`timescale 1ns/10ps

module p4_ingress_asserts (
    input logic       core_clk,
    input logic       core_rstn,
    input logic       grant_p1,
    input logic       out_tvalid,
    input logic       out_tready,
    input logic       out_tlast,
    input logic       out_meta_valid
);

    // --------------------------------------------------
    // merge grant and metadata strobe rules.
    // --------------------------------------------------

    // a beat in the middle of a packet keeps the lane for the next beat.
    grant_held_mid_pkt: assert property (@(posedge core_clk) disable iff (!core_rstn)
        (out_tvalid && out_tready && !out_tlast) |=> $stable(grant_p1))
        else $error("grant moved inside a packet");

    // a stalled beat keeps its lane, also in the cycle the merge picks it.
    grant_held_on_stall: assert property (@(posedge core_clk) disable iff (!core_rstn)
        (out_tvalid && !out_tready) |=> $stable(grant_p1))
        else $error("grant moved during a stall");

    // the strobe never follows a beat that did not end its packet.
    meta_first_beat_only: assert property (@(posedge core_clk) disable iff (!core_rstn)
        (out_tvalid && out_tready && !out_tlast) |=> !out_meta_valid)
        else $error("metadata strobe after a mid-packet beat");

endmodule : p4_ingress_asserts

bind pkt_merge p4_ingress_asserts merge_asserts (
    .core_clk       (core_clk),
    .core_rstn      (core_rstn),
    .grant_p1       (grant_p1),
    .out_tvalid     (out_tvalid),
    .out_tready     (out_tready),
    .out_tlast      (out_tlast),
    .out_meta_valid (out_meta_valid)
);

//--- test/tb_packets.svh
`ifndef TB_PACKETS_SVH
`define TB_PACKETS_SVH

// --------------------------------------------------
// packet stimulus table.
// --------------------------------------------------
// one column per packet:
// port, beat count, keep on the last beat, destination type, expected drop.

localparam int NUM_PKTS = 12;

localparam int PKT_PORT [NUM_PKTS] = '{0, 1, 0, 0, 1, 1, 0, 1, 1, 0, 1, 0};

localparam int PKT_BEATS [NUM_PKTS] = '{3, 2, 1, 2, 4, 1, 5, 3, 1, 2, 2, 4};

localparam int PKT_LAST_KEEP [NUM_PKTS] = '{
    'hff, 'h0f, 'h00, 'h01, 'hff, 'h03, 'h7f, 'hff, 'h00, 'hff, 'h1f, 'h00
};

localparam int PKT_TYP [NUM_PKTS] = '{
    int'(net_port_pkg::PF),
    int'(net_port_pkg::VF0),
    int'(net_port_pkg::PHY),
    int'(net_port_pkg::APP_IGR),
    int'(net_port_pkg::UNSET),
    int'(net_port_pkg::VF2),
    int'(net_port_pkg::PHY),
    int'(net_port_pkg::PF),
    int'(net_port_pkg::VF0),
    int'(net_port_pkg::UNSET),
    int'(net_port_pkg::PHY),
    int'(net_port_pkg::VF2)
};

// zero-length single beats and UNSET destinations are dropped.
// a multi-beat packet with an empty last keep still passes.
localparam bit PKT_DROP [NUM_PKTS] = '{0, 0, 1, 0, 1, 0, 0, 0, 1, 1, 0, 0};

`endif

//--- test/tb_p4_ingress.sv
`timescale 1ns/10ps

module tb_p4_ingress;

    `include "tb_packets.svh"

    localparam int DATA_BYTES = 8;
    localparam int RST_CYCLES = 16;

    logic                   core_clk;
    logic                   core_rstn;
    logic [31:0]            ts_count;
    logic                   in_tvalid [2];
    logic                   in_tready [2];
    logic [63:0]            in_tdata [2];
    logic [7:0]             in_tkeep [2];
    logic                   in_tlast [2];
    net_port_pkg::port_t    in_tid [2];
    net_port_pkg::port_t    in_tdest [2];
    logic                   out_tvalid;
    logic [63:0]            out_tdata;
    logic [7:0]             out_tkeep;
    logic                   out_tlast;
    net_port_pkg::port_t    out_tid;
    net_port_pkg::port_t    out_tdest;
    p4_meta_pkg::pkt_meta_t out_meta;
    logic                   out_meta_valid;
    logic                   out_tready;

    integer      seed;
    int          cycles;
    // idle gap after a packet, drawn before the drivers start.
    bit          gap_after [NUM_PKTS];
    // expected beats as {tlast, tkeep, tid, tdest, tdata}.
    logic [80:0] exp_q0 [$];
    logic [80:0] exp_q1 [$];

    // monitor state.
    logic         first_out;
    logic         held_valid;
    logic [113:0] held_beat;
    int           cur_port;
    logic [31:0]  cur_ts;
    bit           have_last;
    int           last_port;
    bit           both_waiting;
    logic [31:0]  last_ts [2];

    p4_ingress #(.DATA_BYTES(DATA_BYTES)) UUT (
        .core_clk       (core_clk),
        .core_rstn      (core_rstn),
        .timestamp      (ts_count),
        .in0_tvalid     (in_tvalid[0]),
        .in0_tready     (in_tready[0]),
        .in0_tdata      (in_tdata[0]),
        .in0_tkeep      (in_tkeep[0]),
        .in0_tlast      (in_tlast[0]),
        .in0_tid        (in_tid[0]),
        .in0_tdest      (in_tdest[0]),
        .in1_tvalid     (in_tvalid[1]),
        .in1_tready     (in_tready[1]),
        .in1_tdata      (in_tdata[1]),
        .in1_tkeep      (in_tkeep[1]),
        .in1_tlast      (in_tlast[1]),
        .in1_tid        (in_tid[1]),
        .in1_tdest      (in_tdest[1]),
        .out_tvalid     (out_tvalid),
        .out_tdata      (out_tdata),
        .out_tkeep      (out_tkeep),
        .out_tlast      (out_tlast),
        .out_tid        (out_tid),
        .out_tdest      (out_tdest),
        .out_meta       (out_meta),
        .out_meta_valid (out_meta_valid),
        .out_tready     (out_tready)
    );

    // --------------------------------------------------
    // clock, timestamp, output ready and timeout.
    // --------------------------------------------------
    initial begin
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;
    end

    function automatic int total_beats();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_PKTS; i++) begin
            sum += PKT_BEATS[i];
        end
        return sum;
    endfunction

    always @(posedge core_clk) begin
        ts_count   <= ts_count + 1;
        out_tready <= (($random(seed) & 3) != 0);
        cycles     <= cycles + 1;
        if (cycles >= 40 * total_beats() + RST_CYCLES) begin
            $display("timeout: packets did not drain within %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // --------------------------------------------------
    // per-port driver.
    // --------------------------------------------------
    task automatic drive_port(input int port);
        logic [3:0]  tid;
        logic [3:0]  tdest;
        logic [63:0] data;
        logic [7:0]  keep;
        bit          last;
        tid = {3'(net_port_pkg::PHY), port[0]};
        @(posedge core_clk);
        for (int idx = 0; idx < NUM_PKTS; idx++) begin
            if (PKT_PORT[idx] == port) begin
                tdest = {PKT_TYP[idx][2:0], port[0]};
                for (int b = 0; b < PKT_BEATS[idx]; b++) begin
                    data = {idx[31:0], b[31:0]};
                    last = (b == PKT_BEATS[idx] - 1);
                    keep = last ? PKT_LAST_KEEP[idx][7:0] : 8'hff;
                    if (!PKT_DROP[idx]) begin
                        if (port == 0) exp_q0.push_back({last, keep, tid, tdest, data});
                        else exp_q1.push_back({last, keep, tid, tdest, data});
                    end
                    in_tvalid[port] <= 1'b1;
                    in_tdata[port]  <= data;
                    in_tkeep[port]  <= keep;
                    in_tlast[port]  <= last;
                    in_tid[port]    <= tid;
                    in_tdest[port]  <= tdest;
                    @(negedge core_clk);
                    // a dropped beat is taken at once.
                    if (PKT_DROP[idx]) begin
                        check("dropped beat accepted", 1, in_tready[port]);
                    end
                    while (!in_tready[port]) @(negedge core_clk);
                    @(posedge core_clk);
                end
                // idle gap now and then between packets.
                if (gap_after[idx]) begin
                    in_tvalid[port] <= 1'b0;
                    @(posedge core_clk);
                end
            end
        end
        in_tvalid[port] <= 1'b0;
    endtask

    // --------------------------------------------------
    // output monitor and scoreboard.
    // --------------------------------------------------
    always @(negedge core_clk) begin : monitor
        logic [113:0] got;
        logic [80:0]  exp;
        int           p;
        if (core_rstn) begin
            got = {out_meta, out_tlast, out_tkeep, out_tid, out_tdest, out_tdata};
            if (held_valid) begin
                check("held beat valid", 1, out_tvalid);
                check("held beat stable", held_beat, got);
            end
            check("meta valid", out_tvalid && first_out, out_meta_valid);
            // lanes waiting when the merge picks the next packet.
            if (out_tvalid && first_out && !held_valid) begin
                both_waiting = UUT.lane0_s.tvalid && UUT.lane1_s.tvalid;
            end
            if (out_tvalid && out_tready) begin
                p = int'(out_meta.proc_port);
                if (first_out) begin
                    if (have_last && both_waiting) begin
                        check("round robin port", 1 - last_port, p);
                    end
                    check("timestamp order", 1, out_meta.timestamp >= last_ts[p]);
                    check("timestamp bound", 1, out_meta.timestamp <= ts_count);
                    cur_port = p;
                    cur_ts   = out_meta.timestamp;
                    last_ts[p] = out_meta.timestamp;
                end
                check("port inside packet", cur_port, p);
                check("timestamp inside packet", cur_ts, out_meta.timestamp);
                if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
                    $display("output beat on port %0d with no packet expected", p);
                    $display("SIMULATION FAILED");
                    $fatal(1);
                end
                exp = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                check("output beat", exp, got[80:0]);
                if (out_tlast) begin
                    have_last = 1'b1;
                    last_port = p;
                end
                first_out = out_tlast;
            end
            held_valid = out_tvalid && !out_tready;
            held_beat  = got;
        end
    end

    // --------------------------------------------------
    // main sequence.
    // --------------------------------------------------
    initial begin
        seed         = 32'hc7ace00d;
        cycles       = 0;
        ts_count     = '0;
        out_tready   = 1'b0;
        core_rstn    = 1'b0;
        first_out    = 1'b1;
        held_valid   = 1'b0;
        held_beat    = '0;
        cur_port     = 0;
        cur_ts       = '0;
        have_last    = 1'b0;
        last_port    = 0;
        both_waiting = 1'b0;
        for (int i = 0; i < NUM_PKTS; i++) begin
            gap_after[i] = (($random(seed) & 1) != 0);
        end
        for (int i = 0; i < 2; i++) begin
            in_tvalid[i] = 1'b0;
            in_tdata[i]  = '0;
            in_tkeep[i]  = '0;
            in_tlast[i]  = 1'b0;
            in_tid[i]    = '0;
            in_tdest[i]  = '0;
            last_ts[i]   = '0;
        end
        repeat (RST_CYCLES) @(posedge core_clk);
        core_rstn <= 1'b1;

        fork
            drive_port(0);
            drive_port(1);
        join

        while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge core_clk);
        repeat (8) @(posedge core_clk);

        if (exp_q0.size() == 0 && exp_q1.size() == 0 && first_out && !out_tvalid) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("output did not end on a packet boundary or extra beats remain");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule : tb_p4_ingress

//--- all.f
+incdir+test
source/net_port_pkg.sv
source/p4_meta_pkg.sv
source/pkt_stream_if.sv
source/port_lane.sv
source/pkt_merge.sv
source/p4_ingress.sv
test/p4_ingress_asserts.sv
test/tb_p4_ingress.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the p4_ingress testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_p4_ingress -f all.f -o sim_tb_p4_ingress
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb_p4_ingress
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
